// File: include/dcache_macros.svh
// Data cache sizing
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// Word and byte lane widths on both buses.
`define DATA_W 32
`define SEL_W 4

// A word address splits into a tag above a set index.
`define ADDR_W 14
`define INDEX_W 3
`define SET_COUNT 8
`define TAG_W (`ADDR_W - `INDEX_W)

// Pending memory writes held between the processor and memory.
`define BUF_DEPTH 4

`endif

// File: source/dcache_pkg.sv
// Data cache shared types
`include "dcache_macros.svh"

package dcache_pkg;

	// Operation codes used on both the processor and memory buses.
	typedef enum logic [1:0] {
		OP_NOOP  = 2'b00,
		OP_WRITE = 2'b01,
		OP_READ  = 2'b10
	} bus_op_e;

	typedef struct packed {
		logic [`TAG_W-1:0]   tag;
		logic [`INDEX_W-1:0] index;
	} addr_fields_t;

	// The cache looks at a word address as tag and set, the buses as one number.
	typedef union packed {
		logic [`ADDR_W-1:0] flat;
		addr_fields_t       fields;
	} word_addr_u;

	typedef struct packed {
		bus_op_e            op;
		word_addr_u         addr;
		logic [`DATA_W-1:0] data;
		logic [`SEL_W-1:0]  sel;
	} cpu_req_t;

	typedef struct packed {
		bus_op_e            op;
		word_addr_u         addr;
		logic [`DATA_W-1:0] data;
		logic [`SEL_W-1:0]  sel;
	} mem_req_t;

	// A write waiting its turn on the memory bus.
	typedef struct packed {
		word_addr_u         addr;
		logic [`DATA_W-1:0] data;
		logic [`SEL_W-1:0]  sel;
	} buf_entry_t;

endpackage

// File: source/dcache_store.sv
// Data cache store
`timescale 1ns/10ps
`include "dcache_macros.svh"

module dcache_store import dcache_pkg::*; (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic               lookup_i,
	input  cpu_req_t           req_i,
	input  logic               fill_i,
	input  logic [`DATA_W-1:0] fill_data_i,
	output logic               sweep_done_o,
	output logic               hit_o,
	output logic [`DATA_W-1:0] hit_data_o
);

	// One entry per set, since the cache is direct mapped.
	logic [`TAG_W-1:0]   tag_q   [`SET_COUNT];
	logic [`DATA_W-1:0]  data_q  [`SET_COUNT];
	logic [`SEL_W-1:0]   valid_q [`SET_COUNT];

	logic [`INDEX_W-1:0] sweep_idx_q;
	logic                sweep_done_q;

	logic [`INDEX_W-1:0] idx;
	logic                tag_hit;
	logic                wr_en;
	logic [`DATA_W-1:0]  wr_data;
	logic [`SEL_W-1:0]   wr_sel;
	logic [`DATA_W-1:0]  wr_mask;
	logic [`DATA_W-1:0]  merged;

	assign idx     = req_i.addr.fields.index;
	assign tag_hit = (tag_q[idx] == req_i.addr.fields.tag);

	// A read hits only if every byte it selects is held for this tag.
	assign hit_o      = lookup_i && (req_i.op == OP_READ) && tag_hit &&
		((valid_q[idx] & req_i.sel) == req_i.sel);
	assign hit_data_o = data_q[idx];

	// A fill brings the whole word, a write only the bytes it selects.
	assign wr_en   = fill_i || (lookup_i && (req_i.op == OP_WRITE));
	assign wr_data = fill_i ? fill_data_i : req_i.data;
	assign wr_sel  = fill_i ? {`SEL_W{1'b1}} : req_i.sel;

	always_comb begin
		for (int b = 0; b < `SEL_W; b++) begin
			wr_mask[b*8 +: 8] = {8{wr_sel[b]}};
		end
	end

	assign merged = (wr_data & wr_mask) | (data_q[idx] & ~wr_mask);

	// After reset the valid masks are cleared one set per cycle.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			sweep_idx_q  <= '0;
			sweep_done_q <= 1'b0;
		end else if (!sweep_done_q) begin
			valid_q[sweep_idx_q] <= '0;
			sweep_idx_q          <= sweep_idx_q + 1'b1;
			if (sweep_idx_q == (`SET_COUNT - 1)) begin
				sweep_done_q <= 1'b1;
			end
		end else if (wr_en) begin
			// A new tag takes over the set with only the bytes just written.
			if (tag_hit) begin
				valid_q[idx] <= valid_q[idx] | wr_sel;
			end else begin
				valid_q[idx] <= wr_sel;
			end
		end
	end

	// The tag is rewritten on every update; on a hit it stays the same.
	always_ff @(posedge clk_i) begin
		if (wr_en) begin
			tag_q[idx]  <= req_i.addr.fields.tag;
			data_q[idx] <= merged;
		end
	end

	assign sweep_done_o = sweep_done_q;

endmodule

// File: source/write_buffer.sv
// Memory write buffer
`timescale 1ns/10ps
`include "dcache_macros.svh"

module write_buffer import dcache_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       push_i,
	input  buf_entry_t entry_i,
	input  logic       pop_i,
	output buf_entry_t head_o,
	output logic       empty_o,
	output logic       full_o
);

	localparam int PTR_W = $clog2(`BUF_DEPTH);

	buf_entry_t         mem_q [`BUF_DEPTH];
	logic [PTR_W-1:0]   wr_ptr_q;
	logic [PTR_W-1:0]   rd_ptr_q;
	logic [PTR_W:0]     count_q;

	always_ff @(posedge clk_i) begin
		if (push_i) begin
			mem_q[wr_ptr_q] <= entry_i;
		end
	end

	// Pointers wrap naturally because the depth is a power of two.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push_i) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop_i) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({push_i, pop_i})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	assign head_o  = mem_q[rd_ptr_q];
	assign empty_o = (count_q == '0);
	assign full_o  = (count_q == (PTR_W+1)'(`BUF_DEPTH));

endmodule

// File: source/bus_sequencer.sv
// Cache bus sequencer
`timescale 1ns/10ps
`include "dcache_macros.svh"

module bus_sequencer import dcache_pkg::*; (
	input  logic               clk_i,
	input  logic               rst_i,
	input  cpu_req_t           cpu_req_i,
	output logic               cpu_rdy_o,
	output logic [`DATA_W-1:0] cpu_data_o,
	output mem_req_t           mem_req_o,
	input  logic [`DATA_W-1:0] mem_data_i,
	input  logic               mem_rdy_i,
	input  logic               sweep_done_i,
	input  logic               hit_i,
	input  logic [`DATA_W-1:0] hit_data_i,
	output logic               lookup_o,
	output logic               fill_o,
	output logic [`DATA_W-1:0] fill_data_o,
	output logic               push_o,
	output buf_entry_t         entry_o,
	output logic               pop_o,
	input  buf_entry_t         head_i,
	input  logic               empty_i,
	input  logic               full_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WRITING,
		ST_MISS_DRAIN,
		ST_MISS_READ
	} seq_state_e;

	seq_state_e         state_q;
	logic               lookup_q;
	cpu_req_t           req_q;
	logic [`DATA_W-1:0] rdata_q;

	logic               accept;
	logic               rd_miss;
	logic               miss_busy;

	// The lookup of the request taken at the last edge runs this cycle.
	assign rd_miss   = lookup_q && (req_q.op == OP_READ) && !hit_i;
	assign miss_busy = (state_q == ST_MISS_DRAIN) || (state_q == ST_MISS_READ);

	assign cpu_rdy_o = sweep_done_i && !miss_busy && !rd_miss && !full_i;
	assign accept    = cpu_rdy_o && (cpu_req_i.op != OP_NOOP);

	// Hit data during the lookup cycle, otherwise the word fetched on a miss.
	assign cpu_data_o = lookup_q ? hit_data_i : rdata_q;

	// Writes enter the buffer at the same edge that accepts them.
	assign push_o       = accept && (cpu_req_i.op == OP_WRITE);
	assign entry_o.addr = cpu_req_i.addr;
	assign entry_o.data = cpu_req_i.data;
	assign entry_o.sel  = cpu_req_i.sel;

	assign lookup_o    = lookup_q;
	assign fill_o      = (state_q == ST_MISS_READ) && mem_rdy_i;
	assign fill_data_o = mem_data_i;

	assign pop_o = !empty_i && mem_rdy_i;

	// Buffered writes always go first; a miss read waits for an empty buffer.
	always_comb begin
		mem_req_o.op   = OP_NOOP;
		mem_req_o.addr = head_i.addr;
		mem_req_o.data = head_i.data;
		mem_req_o.sel  = head_i.sel;
		if (!empty_i) begin
			mem_req_o.op = OP_WRITE;
		end else if (state_q == ST_MISS_DRAIN) begin
			mem_req_o.op   = OP_READ;
			mem_req_o.addr = req_q.addr;
			mem_req_o.sel  = {`SEL_W{1'b1}};
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q  <= ST_IDLE;
			lookup_q <= 1'b0;
		end else begin
			lookup_q <= accept;
			case (state_q)
				ST_IDLE, ST_WRITING: begin
					if (rd_miss) begin
						state_q <= ST_MISS_DRAIN;
					end else if (pop_o) begin
						state_q <= ST_WRITING;
					end else if (mem_rdy_i) begin
						state_q <= ST_IDLE;
					end
				end
				ST_MISS_DRAIN: begin
					// The read goes out on the first ready edge after the last write.
					if (empty_i && mem_rdy_i) begin
						state_q <= ST_MISS_READ;
					end
				end
				ST_MISS_READ: begin
					if (mem_rdy_i) begin
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			req_q <= cpu_req_i;
		end
		if (fill_o) begin
			rdata_q <= mem_data_i;
		end
	end

endmodule

// File: source/dcache_top.sv
// Write-through data cache
`timescale 1ns/10ps
`include "dcache_macros.svh"

module dcache_top import dcache_pkg::*; (
	input  logic               clk_i,
	input  logic               rst_i,
	input  cpu_req_t           cpu_req_i,
	output logic [`DATA_W-1:0] cpu_data_o,
	output logic               cpu_rdy_o,
	output mem_req_t           mem_req_o,
	input  logic [`DATA_W-1:0] mem_data_i,
	input  logic               mem_rdy_i
);

	logic               lookup;
	logic               fill;
	logic [`DATA_W-1:0] fill_data;
	logic               sweep_done;
	logic               hit;
	logic [`DATA_W-1:0] hit_data;
	logic               push;
	buf_entry_t         entry;
	logic               pop;
	buf_entry_t         head;
	logic               empty;
	logic               full;

	// The store sees the request held by the sequencer, not the live bus.
	cpu_req_t           held_req;

	dcache_store u_store (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.lookup_i     (lookup),
		.req_i        (held_req),
		.fill_i       (fill),
		.fill_data_i  (fill_data),
		.sweep_done_o (sweep_done),
		.hit_o        (hit),
		.hit_data_o   (hit_data)
	);

	write_buffer u_wbuf (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.push_i  (push),
		.entry_i (entry),
		.pop_i   (pop),
		.head_o  (head),
		.empty_o (empty),
		.full_o  (full)
	);

	bus_sequencer u_seq (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.cpu_req_i    (cpu_req_i),
		.cpu_rdy_o    (cpu_rdy_o),
		.cpu_data_o   (cpu_data_o),
		.mem_req_o    (mem_req_o),
		.mem_data_i   (mem_data_i),
		.mem_rdy_i    (mem_rdy_i),
		.sweep_done_i (sweep_done),
		.hit_i        (hit),
		.hit_data_i   (hit_data),
		.lookup_o     (lookup),
		.fill_o       (fill),
		.fill_data_o  (fill_data),
		.push_o       (push),
		.entry_o      (entry),
		.pop_o        (pop),
		.head_i       (head),
		.empty_i      (empty),
		.full_i       (full)
	);

	assign held_req = u_seq.req_q;

endmodule

// File: bench/dcache_tb.sv
// Data cache testbench
`timescale 1ns/10ps
`include "dcache_macros.svh"

module dcache_tb import dcache_pkg::*; ();

	localparam int MAX_CASES = 64;
	localparam int MEM_WORDS = 1 << `ADDR_W;

	logic               clk_i = 1'b0;
	logic               rst_i;
	cpu_req_t           cpu_req_i;
	logic [`DATA_W-1:0] cpu_data_o;
	logic               cpu_rdy_o;
	mem_req_t           mem_req_o;
	logic [`DATA_W-1:0] mem_data_i;
	logic               mem_rdy_i;

	logic [31:0]        case_words [4*MAX_CASES];
	logic [`DATA_W-1:0] mem [MEM_WORDS];
	logic [`DATA_W-1:0] ref_mem [MEM_WORDS];
	buf_entry_t         exp_writes [$];
	buf_entry_t         expected_write;
	buf_entry_t         case_write;

	integer             seed;
	int                 case_count;
	int                 cycle_count;
	int                 cycle_limit;
	int                 error_count;
	int                 mem_read_count;
	int                 reads_before;
	logic [31:0]        kind;
	logic [`ADDR_W-1:0] addr;
	logic [`DATA_W-1:0] data;
	logic [`SEL_W-1:0]  sel;
	logic [`ADDR_W-1:0] pending_read_addr;
	logic [`ADDR_W-1:0] last_read_addr;
	logic               last_read_ok;
	logic               check_repeat;

	dcache_top u_dut (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.cpu_req_i  (cpu_req_i),
		.cpu_data_o (cpu_data_o),
		.cpu_rdy_o  (cpu_rdy_o),
		.mem_req_o  (mem_req_o),
		.mem_data_i (mem_data_i),
		.mem_rdy_i  (mem_rdy_i)
	);

	always #20 clk_i = ~clk_i;

	// Each memory word starts as its own address in both halves.
	function automatic logic [`DATA_W-1:0] initial_word(int a);
		return {a[15:0], a[15:0]};
	endfunction

	function automatic logic [`DATA_W-1:0] lane_mask(logic [`SEL_W-1:0] s);
		logic [`DATA_W-1:0] m;
		for (int b = 0; b < `SEL_W; b++) begin
			m[b*8 +: 8] = {8{s[b]}};
		end
		return m;
	endfunction

	function automatic logic [`DATA_W-1:0] merge_word(logic [`DATA_W-1:0] old_w,
		logic [`DATA_W-1:0] new_w, logic [`SEL_W-1:0] s);
		return (new_w & lane_mask(s)) | (old_w & ~lane_mask(s));
	endfunction

	always @(posedge clk_i) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, the cache stopped making progress", cycle_count);
			$display(">>> FAIL");
			$finish;
		end
	end

	// Memory model. The request seen before a ready edge is the one issued at that edge.
	always @(negedge clk_i) begin
		mem_rdy_i = (($random(seed) & 3) != 0);
		if (mem_rdy_i && mem_req_o.op == OP_WRITE) begin
			if (exp_writes.size() == 0) begin
				$display("A memory write was issued at %0t with no case write pending", $time);
				error_count++;
			end else begin
				expected_write = exp_writes.pop_front();
				if (mem_req_o.addr.flat != expected_write.addr.flat ||
					mem_req_o.data != expected_write.data ||
					mem_req_o.sel != expected_write.sel) begin
					$display("Mismatch at %0t: memory write %h/%h/%h, expected %h/%h/%h",
						$time, mem_req_o.addr.flat, mem_req_o.data, mem_req_o.sel,
						expected_write.addr.flat, expected_write.data, expected_write.sel);
					error_count++;
				end
			end
			mem[mem_req_o.addr.flat] = merge_word(mem[mem_req_o.addr.flat],
				mem_req_o.data, mem_req_o.sel);
		end else if (mem_rdy_i && mem_req_o.op == OP_READ) begin
			mem_read_count++;
			if (exp_writes.size() != 0) begin
				$display("A memory read was issued at %0t before earlier writes went out", $time);
				error_count++;
			end
			if (mem_req_o.sel != {`SEL_W{1'b1}} || mem_req_o.addr.flat != pending_read_addr) begin
				$display("Mismatch at %0t: miss read of %h with select %h, expected %h",
					$time, mem_req_o.addr.flat, mem_req_o.sel, pending_read_addr);
				error_count++;
			end
			mem_data_i = mem[mem_req_o.addr.flat];
		end
	end

	initial begin
		rst_i = 1'b1;
		cpu_req_i = '0;
		mem_data_i = '0;
		mem_rdy_i = 1'b0;
		seed = 32'h99023e6a;
		error_count = 0;
		mem_read_count = 0;
		cycle_count = 0;
		last_read_ok = 1'b0;
		pending_read_addr = '0;
		for (int a = 0; a < MEM_WORDS; a++) begin
			mem[a] = initial_word(a);
			ref_mem[a] = initial_word(a);
		end
		for (int w = 0; w < 4*MAX_CASES; w++) begin
			case_words[w] = '0;
		end
		$readmemh("bench/dcache_cases.txt", case_words);
		case_count = 0;
		while (case_count < MAX_CASES && case_words[4*case_count] != 0) begin
			case_count++;
		end
		cycle_limit = 20*case_count + 200;
		if (case_count == 0) begin
			$display("No cases could be read from the case file");
			error_count++;
		end

		// Nothing may move during reset and the valid sweep that follows.
		for (int c = 0; c < 5 + `SET_COUNT - 1; c++) begin
			@(negedge clk_i);
			if (c == 4) begin
				rst_i = 1'b0;
			end
			if (cpu_rdy_o !== 1'b0 || mem_req_o.op !== OP_NOOP) begin
				$display("Mismatch at %0t: cache active before the sweep ended", $time);
				error_count++;
			end
		end

		for (int i = 0; i < case_count; i++) begin
			kind = case_words[4*i];
			addr = case_words[4*i+1][`ADDR_W-1:0];
			data = case_words[4*i+2][`DATA_W-1:0];
			sel  = case_words[4*i+3][`SEL_W-1:0];
			while (!cpu_rdy_o) begin
				@(negedge clk_i);
			end
			cpu_req_i.addr.flat = addr;
			cpu_req_i.data = data;
			cpu_req_i.sel = sel;
			if (kind == 1) begin
				cpu_req_i.op = OP_WRITE;
				case_write.addr.flat = addr;
				case_write.data = data;
				case_write.sel = sel;
				exp_writes.push_back(case_write);
				ref_mem[addr] = merge_word(ref_mem[addr], data, sel);
				last_read_ok = 1'b0;
				@(negedge clk_i);
				cpu_req_i.op = OP_NOOP;
			end else begin
				cpu_req_i.op = OP_READ;
				check_repeat = last_read_ok && (addr == last_read_addr);
				reads_before = mem_read_count;
				pending_read_addr = addr;
				@(negedge clk_i);
				cpu_req_i.op = OP_NOOP;
				while (!cpu_rdy_o) begin
					@(negedge clk_i);
				end
				if ((cpu_data_o & lane_mask(sel)) !== (ref_mem[addr] & lane_mask(sel))) begin
					$display("Mismatch at %0t: read of %h returned %h, expected %h",
						$time, addr, cpu_data_o, ref_mem[addr]);
					error_count++;
				end
				if (check_repeat && mem_read_count != reads_before) begin
					$display("Mismatch at %0t: repeated read of %h went to memory", $time, addr);
					error_count++;
				end
				last_read_addr = addr;
				last_read_ok = 1'b1;
			end
		end

		while (exp_writes.size() != 0) begin
			@(negedge clk_i);
		end
		$display("Summary: %0d cases, %0d memory reads, %0d errors",
			case_count, mem_read_count, error_count);
		if (error_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: compile.f
+incdir+include
source/dcache_pkg.sv
source/dcache_store.sv
source/write_buffer.sv
source/bus_sequencer.sv
source/dcache_top.sv
bench/dcache_tb.sv

// File: bench/dcache_cases.txt
// Columns: kind (1 write, 2 read), word address, data, byte select.
// Read lines carry a zero data column; the bench works out the expected word.
2 0005 00000000 f
2 0005 00000000 f
1 0005 a5a5a5a5 3
2 0005 00000000 f
1 000d 11223344 f
2 000d 00000000 f
2 0005 00000000 f
1 0100 deadbeef c
2 0100 00000000 f
2 0100 00000000 f
1 0021 cafe0001 1
1 0022 cafe0002 2
1 0023 cafe0003 4
1 0024 cafe0004 8
1 0025 cafe0005 f
1 0026 cafe0006 6
2 0021 00000000 f
2 0026 00000000 f
2 0025 00000000 f
2 0025 00000000 f
1 3ff7 12345678 f
2 3ff7 00000000 f
2 1fff 00000000 f
2 3ff7 00000000 f
1 2000 0000ffff 3
2 2000 00000000 f
2 0022 00000000 f
2 0022 00000000 f
